//--- aes_pkg.sv
// Shared definitions for the pipelined AES-128 encryptor.
// Holds the block widths, the round count, the block type with its word and
// byte views, and the GF(2^8) helpers used by the round and key stages.
// Modules and the testbench refer to everything here by scoped names.

`default_nettype none

package aes_pkg;

    // block and column sizes
    localparam int block_width = 128;
    localparam int word_width  = 32;

    // rounds for a 128-bit key
    localparam int num_rounds = 10;

    // one state or key block, seen either as column words or as bytes
    // word 0 and byte 0 sit at the most significant end
    typedef union packed {
        logic [0:block_width/word_width-1][word_width-1:0] words;
        logic [0:block_width/8-1][7:0]                     bytes;
    } aes_block_t;

    // multiply by x modulo x^8+x^4+x^3+x+1
    function automatic logic [7:0] xtime(input logic [7:0] value);
        logic [7:0] shifted;
        shifted = {value[6:0], 1'b0};
        if (value[7])
        begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

    // general field product by shift and add
    function automatic logic [7:0] gf_mul(
        input logic [7:0] a,
        input logic [7:0] b
    );
        logic [7:0] product;
        logic [7:0] term;
        product = 8'h00;
        term    = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
            begin
                product = product ^ term;
            end
            term = xtime(term);
        end
        return product;
    endfunction

    // inverse as a^254, built from a^2 * a^4 * ... * a^128
    // zero has no inverse and comes out as zero
    function automatic logic [7:0] gf_inv(input logic [7:0] value);
        logic [7:0] power;
        logic [7:0] result;
        power  = value;
        result = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            power  = gf_mul(power, power);
            result = gf_mul(result, power);
        end
        return result;
    endfunction

    // forward S-box: field inverse, then the affine map
    function automatic logic [7:0] sbox(input logic [7:0] value);
        logic [7:0] inv;
        logic [7:0] rot1;
        logic [7:0] rot2;
        logic [7:0] rot3;
        logic [7:0] rot4;
        inv  = gf_inv(value);
        rot1 = {inv[6:0], inv[7]};
        rot2 = {inv[5:0], inv[7:6]};
        rot3 = {inv[4:0], inv[7:5]};
        rot4 = {inv[3:0], inv[7:4]};
        return inv ^ rot1 ^ rot2 ^ rot3 ^ rot4 ^ 8'h63;
    endfunction

    // round constant for key schedule step 1 to num_rounds
    // 01, 02, 04 ... 80, then 1b and 36 after the reduction kicks in
    function automatic logic [7:0] rcon(input int round_idx);
        logic [7:0] constant;
        constant = 8'h01;
        for (int i = 2; i <= num_rounds; i++)
        begin
            if (i <= round_idx)
            begin
                constant = xtime(constant);
            end
        end
        return constant;
    endfunction

endpackage

`default_nettype wire

//--- aes_key_expand_stage.sv
// One step of the AES-128 key schedule.
// Takes the previous round key, derives the next one combinationally for
// the round in the same stage, and registers it for the following stage.
// round_index picks the round constant and runs from 1 to 10.

`timescale 1ns/10ps
`default_nettype none

module aes_key_expand_stage #(
    parameter int round_index = 1
) (
    input  wire logic               clk,
    input  wire aes_pkg::aes_block_t key_prev,
    output aes_pkg::aes_block_t      key_next,
    output aes_pkg::aes_block_t      key_q
);

    localparam int ww = aes_pkg::word_width;

    // fixed per stage, folded away in synthesis
    localparam logic [7:0] round_const = aes_pkg::rcon(round_index);

    logic [ww-1:0] rot_word;
    logic [ww-1:0] sub_word;
    logic [ww-1:0] mix_word;

    // RotWord and SubWord on the last column of the previous key
    assign rot_word = {key_prev.words[3][ww-9:0], key_prev.words[3][ww-1:ww-8]};

    assign sub_word = {aes_pkg::sbox(rot_word[31:24]), aes_pkg::sbox(rot_word[23:16]),
                       aes_pkg::sbox(rot_word[15:8]),  aes_pkg::sbox(rot_word[7:0])};

    // round constant only touches the top byte
    assign mix_word = sub_word ^ {round_const, {(ww-8){1'b0}}};

    // each new word is the previous new word xor the old word at that position
    always_comb
    begin : chain_words
        logic [ww-1:0] acc;
        acc = mix_word;
        for (int i = 0; i < aes_pkg::block_width/ww; i++)
        begin
            acc = acc ^ key_prev.words[i];
            key_next.words[i] = acc;
        end
    end

    always_ff @(posedge clk)
    begin
        key_q <= key_next;
    end

endmodule

`default_nettype wire

//--- aes_round.sv
// One AES cipher round as a single pipeline stage.
// SubBytes, ShiftRows, MixColumns and AddRoundKey are all done in one
// cycle and the result is registered. Setting final_round drops
// MixColumns, as the last round of the cipher requires.

`timescale 1ns/10ps
`default_nettype none

module aes_round #(
    parameter bit final_round = 1'b0
) (
    input  wire logic               clk,
    input  wire aes_pkg::aes_block_t state_in,
    input  wire aes_pkg::aes_block_t round_key,
    output aes_pkg::aes_block_t      state_out
);

    localparam int num_cols = aes_pkg::block_width / aes_pkg::word_width;

    aes_pkg::aes_block_t sub_state;
    aes_pkg::aes_block_t shift_state;
    aes_pkg::aes_block_t mix_state;
    aes_pkg::aes_block_t next_state;

    // SubBytes over all sixteen bytes
    always_comb
    begin
        for (int i = 0; i < 4*num_cols; i++)
        begin
            sub_state.bytes[i] = aes_pkg::sbox(state_in.bytes[i]);
        end
    end

    // byte 4*col+row holds row "row" of column "col"
    // row r rotates left by r columns
    always_comb
    begin
        for (int col = 0; col < num_cols; col++)
        begin
            for (int row = 0; row < 4; row++)
            begin
                shift_state.bytes[4*col + row] =
                    sub_state.bytes[4*((col + row) % num_cols) + row];
            end
        end
    end

    // MixColumns with the 2-3-1-1 matrix
    // b_i = a_i ^ (sum of column) ^ 2*(a_i ^ a_i+1)
    always_comb
    begin : mix_columns
        logic [7:0] col_sum;
        logic [7:0] pair;
        for (int col = 0; col < num_cols; col++)
        begin
            col_sum = shift_state.bytes[4*col]     ^ shift_state.bytes[4*col + 1] ^
                      shift_state.bytes[4*col + 2] ^ shift_state.bytes[4*col + 3];
            for (int row = 0; row < 4; row++)
            begin
                pair = shift_state.bytes[4*col + row] ^
                       shift_state.bytes[4*col + (row + 1) % 4];
                if (final_round)
                begin
                    mix_state.bytes[4*col + row] = shift_state.bytes[4*col + row];
                end
                else
                begin
                    mix_state.bytes[4*col + row] = shift_state.bytes[4*col + row] ^
                                                   col_sum ^ aes_pkg::xtime(pair);
                end
            end
        end
    end

    // AddRoundKey, one column at a time
    always_comb
    begin
        for (int col = 0; col < num_cols; col++)
        begin
            next_state.words[col] = mix_state.words[col] ^ round_key.words[col];
        end
    end

    always_ff @(posedge clk)
    begin
        state_out <= next_state;
    end

endmodule

`default_nettype wire

//--- aes_encrypt_top.sv
// Fully pipelined AES-128 encryptor.
// Accepts one plaintext block and its key on every clock where in_valid is
// high and presents the ciphertext with out_valid 11 cycles later. There is
// no back-pressure, so the consumer takes each result in its cycle.
// Only the valid pipeline is reset; the datapath just follows along.

`timescale 1ns/10ps
`default_nettype none

module aes_encrypt_top (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire logic               in_valid,
    input  wire aes_pkg::aes_block_t plaintext,
    input  wire aes_pkg::aes_block_t key,
    output logic                    out_valid,
    output aes_pkg::aes_block_t      ciphertext
);

    // input stage plus one stage per round
    localparam int pipe_depth = aes_pkg::num_rounds + 1;

    aes_pkg::aes_block_t state_whiten_q;
    aes_pkg::aes_block_t key_start_q;
    logic [pipe_depth-1:0] valid_q;

    // registered state and key leaving each stage, index 0 is the input stage
    wire aes_pkg::aes_block_t stage_state [0:aes_pkg::num_rounds];
    wire aes_pkg::aes_block_t stage_key   [0:aes_pkg::num_rounds-1];

    // unregistered round key handed from key stage to round in the same stage
    wire aes_pkg::aes_block_t round_key [1:aes_pkg::num_rounds];

    // initial AddRoundKey with the cipher key itself
    always_ff @(posedge clk)
    begin
        state_whiten_q <= plaintext ^ key;
        key_start_q    <= key;
    end

    // valid travels alongside the data, one bit per stage
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q <= {valid_q[pipe_depth-2:0], in_valid};
        end
    end

    assign stage_state[0] = state_whiten_q;
    assign stage_key[0]   = key_start_q;

    // each stage carries its own block's key, so blocks with different
    // keys can follow each other on every cycle
    genvar r;
    generate
        for (r = 1; r <= aes_pkg::num_rounds; r++)
        begin : g_stage
            if (r < aes_pkg::num_rounds)
            begin : g_key
                aes_key_expand_stage #(
                    .round_index (r)
                ) key_stage_i (
                    .clk      (clk),
                    .key_prev (stage_key[r-1]),
                    .key_next (round_key[r]),
                    .key_q    (stage_key[r])
                );
            end
            else
            begin : g_key_last
                // last round key feeds only the final round
                aes_key_expand_stage #(
                    .round_index (r)
                ) key_stage_i (
                    .clk      (clk),
                    .key_prev (stage_key[r-1]),
                    .key_next (round_key[r]),
                    .key_q    ()
                );
            end

            aes_round #(
                .final_round (r == aes_pkg::num_rounds)
            ) round_i (
                .clk       (clk),
                .state_in  (stage_state[r-1]),
                .round_key (round_key[r]),
                .state_out (stage_state[r])
            );
        end
    endgenerate

    assign ciphertext = stage_state[aes_pkg::num_rounds];
    assign out_valid  = valid_q[pipe_depth-1];

endmodule

`default_nettype wire

//--- aes_ref_model.svh
// Behavioral AES-128 encryption for the testbench scoreboard.
// Included inside the testbench module; aes_encrypt_ref returns the
// ciphertext for one plaintext and key, using a full key schedule up front
// and a plain matrix form of MixColumns.

`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

function automatic aes_pkg::aes_block_t aes_encrypt_ref(
    input aes_pkg::aes_block_t plain,
    input aes_pkg::aes_block_t cipher_key
);
    aes_pkg::aes_block_t state;
    aes_pkg::aes_block_t sub;
    logic [31:0] w [0:4*aes_pkg::num_rounds+3];
    logic [31:0] t;
    logic [7:0] a [0:3];

    // expand all 44 schedule words
    for (int i = 0; i < 4; i++)
        w[i] = cipher_key.words[i];
    for (int i = 4; i < 4*aes_pkg::num_rounds + 4; i++)
    begin
        t = w[i-1];
        if (i % 4 == 0)
        begin
            t = {t[23:0], t[31:24]};
            t = {aes_pkg::sbox(t[31:24]), aes_pkg::sbox(t[23:16]),
                 aes_pkg::sbox(t[15:8]), aes_pkg::sbox(t[7:0])};
            t = t ^ {aes_pkg::rcon(i/4), 24'h000000};
        end
        w[i] = w[i-4] ^ t;
    end

    state = plain ^ cipher_key;
    for (int rnd = 1; rnd <= aes_pkg::num_rounds; rnd++)
    begin
        for (int i = 0; i < 16; i++)
            sub.bytes[i] = aes_pkg::sbox(state.bytes[i]);
        for (int c = 0; c < 4; c++)
        begin
            for (int row = 0; row < 4; row++)
                a[row] = sub.bytes[4*((c + row) % 4) + row];
            if (rnd != aes_pkg::num_rounds)
            begin
                state.bytes[4*c]   = aes_pkg::xtime(a[0]) ^ aes_pkg::xtime(a[1]) ^ a[1] ^ a[2] ^ a[3];
                state.bytes[4*c+1] = a[0] ^ aes_pkg::xtime(a[1]) ^ aes_pkg::xtime(a[2]) ^ a[2] ^ a[3];
                state.bytes[4*c+2] = a[0] ^ a[1] ^ aes_pkg::xtime(a[2]) ^ aes_pkg::xtime(a[3]) ^ a[3];
                state.bytes[4*c+3] = aes_pkg::xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ aes_pkg::xtime(a[3]);
            end
            else
                state.words[c] = {a[0], a[1], a[2], a[3]};
            state.words[c] = state.words[c] ^ w[4*rnd + c];
        end
    end
    return state;
endfunction

`endif

//--- tb_aes_encrypt.sv
// Testbench for the pipelined AES-128 encryptor.
// Drives known vectors, random back-to-back and gapped traffic and a reset
// in mid-flight, and compares every output block and the valid pattern
// against a behavioral reference model.

`timescale 1ns/10ps
`default_nettype none

module tb_aes_encrypt;

    localparam int pipe_depth  = aes_pkg::num_rounds + 1;
    localparam int drain_limit = 100;

    logic                clk;
    logic                reset;
    logic                in_valid;
    aes_pkg::aes_block_t plaintext;
    aes_pkg::aes_block_t key;
    wire logic           out_valid;
    wire aes_pkg::aes_block_t ciphertext;

    integer seed;
    int     error_count;
    int     check_count;
    int     test_count;

    // expected ciphertexts in output order, plus the expected valid pipeline
    aes_pkg::aes_block_t   expect_q[$];
    logic [pipe_depth-1:0] valid_model;
    bit                    model_live;

    // a known answer rides along with the block in place of the model result
    bit                  drive_fixed;
    aes_pkg::aes_block_t drive_expect;

    `include "aes_ref_model.svh"

    aes_encrypt_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    always #5 clk = ~clk;

    task automatic check_block(
        input string               name,
        input aes_pkg::aes_block_t got,
        input aes_pkg::aes_block_t expected
    );
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("** Error: %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_valid(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("** Error: %s got %h expected %h", name, got, expected);
        end
    endtask

    // compare before the model moves on, all in one process
    always @(posedge clk)
    begin : compare_outputs
        aes_pkg::aes_block_t expected;
        if (model_live)
        begin
            check_valid("out_valid", out_valid, valid_model[pipe_depth-1]);
            if (out_valid === 1'b1)
            begin
                if (expect_q.size() == 0)
                begin
                    error_count++;
                    $display("ciphertext came out while no block was pending");
                end
                else
                begin
                    expected = expect_q.pop_front();
                    check_block("ciphertext", ciphertext, expected);
                end
            end
        end
        if (reset)
        begin
            valid_model = '0;
            expect_q.delete();
            model_live = 1'b1;
        end
        else if (model_live)
        begin
            valid_model = {valid_model[pipe_depth-2:0], in_valid};
            if (in_valid)
            begin
                expect_q.push_back(drive_fixed ? drive_expect :
                                   aes_encrypt_ref(plaintext, key));
            end
        end
    end

    function automatic aes_pkg::aes_block_t random_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic drive_block(
        input aes_pkg::aes_block_t pt,
        input aes_pkg::aes_block_t k,
        input bit                  fixed,
        input aes_pkg::aes_block_t expected
    );
        @(negedge clk);
        in_valid     = 1'b1;
        plaintext    = pt;
        key          = k;
        drive_fixed  = fixed;
        drive_expect = expected;
    endtask

    // data keeps changing while in_valid is low
    task automatic drive_idle();
        @(negedge clk);
        in_valid    = 1'b0;
        drive_fixed = 1'b0;
        plaintext   = random_block();
        key         = random_block();
    endtask

    // waits until the DUT has delivered every pending block
    task automatic wait_drain(input string test_name);
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0 && cycles < drain_limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (expect_q.size() != 0)
        begin
            error_count++;
            $display("%s: pipeline still holds %0d blocks after %0d cycles",
                     test_name, expect_q.size(), drain_limit);
        end
    endtask

    task automatic report_test(input string test_name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            $display("test %s: %0d errors", test_name, error_count - errors_before);
        end
    endtask

    // single block against a fixed answer, model checked too
    task automatic send_vector(
        input string               test_name,
        input aes_pkg::aes_block_t pt,
        input aes_pkg::aes_block_t k,
        input aes_pkg::aes_block_t ct
    );
        int errors_before;
        errors_before = error_count;
        check_block("aes_encrypt_ref", aes_encrypt_ref(pt, k), ct);
        drive_block(pt, k, 1'b1, ct);
        drive_idle();
        wait_drain(test_name);
        report_test(test_name, errors_before);
    endtask

    task automatic stream_random_blocks(input int count);
        int errors_before;
        errors_before = error_count;
        repeat (count)
        begin
            drive_block(random_block(), random_block(), 1'b0, '0);
        end
        drive_idle();
        wait_drain("back-to-back");
        report_test("back-to-back", errors_before);
    endtask

    task automatic send_gapped_blocks(input int cycles);
        int errors_before;
        errors_before = error_count;
        repeat (cycles)
        begin
            if ($random(seed) & 1)
            begin
                drive_block(random_block(), random_block(), 1'b0, '0);
            end
            else
            begin
                drive_idle();
            end
        end
        drive_idle();
        wait_drain("gapped input");
        report_test("gapped input", errors_before);
    endtask

    task automatic reset_during_flight();
        int errors_before;
        errors_before = error_count;
        repeat (8)
        begin
            drive_block(random_block(), random_block(), 1'b0, '0);
        end
        // a block offered while reset is high must be dropped too
        @(negedge clk);
        reset     = 1'b1;
        in_valid  = 1'b1;
        plaintext = random_block();
        key       = random_block();
        repeat (3)
        begin
            @(negedge clk);
            check_valid("out_valid", out_valid, 1'b0);
        end
        reset    = 1'b0;
        in_valid = 1'b0;
        repeat (20)
        begin
            drive_block(random_block(), random_block(), 1'b0, '0);
        end
        drive_idle();
        wait_drain("reset mid-flight");
        report_test("reset mid-flight", errors_before);
    endtask

    initial
    begin
        seed         = 32'h06ad4e27;
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        plaintext    = '0;
        key          = '0;
        drive_fixed  = 1'b0;
        drive_expect = '0;
        valid_model  = '0;
        model_live   = 1'b0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;

        repeat (3) @(negedge clk);
        reset = 1'b0;

        send_vector("known vector", 128'h00112233445566778899aabbccddeeff,
                    128'h000102030405060708090a0b0c0d0e0f,
                    128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        stream_random_blocks(200);
        send_gapped_blocks(300);
        send_vector("all-zero", '0, '0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e);
        reset_during_flight();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
aes_pkg.sv
aes_key_expand_stage.sv
aes_round.sv
aes_encrypt_top.sv
tb_aes_encrypt.sv
